//--- logic/execPkg.sv
package execPkg;

	// **********************************************************************
	// widths that carry a meaning
	// **********************************************************************
	typedef logic [31:0] word_t;    // data or instruction word
	typedef logic [4:0]  regAddr_t; // register number

	typedef enum logic [1:0] {
		extSign,
		extZero,
		extShamt,
		extUpper
	} extMode_t;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluNor,
		aluSlt,
		aluSll,
		aluSrl,
		aluPassB
	} aluOp_t;

	typedef enum logic [1:0] {
		fwdReg, // value from the register file
		fwdEx,  // one stage ahead
		fwdWb   // two stages ahead
	} fwdSel_t;

	typedef enum logic {
		busIdle,
		busAck
	} busState_t;

	typedef struct packed {
		extMode_t ext;
		aluOp_t   aluOp;
		logic     srcAImm; // A takes shamt
		logic     srcBImm; // B takes extended immediate
		fwdSel_t  fwdA;
		fwdSel_t  fwdB;
		regAddr_t dst;
		logic     wbEn;
	} ctrlBundle_t;

	typedef struct packed {
		logic     valid;
		regAddr_t dst;
		word_t    data;
	} wbRecord_t;

	// **********************************************************************
	// opcode and funct encodings
	// **********************************************************************
	localparam logic [5:0] opRType = 6'h00;
	localparam logic [5:0] opAddi  = 6'h08;
	localparam logic [5:0] opSlti  = 6'h0a;
	localparam logic [5:0] opAndi  = 6'h0c;
	localparam logic [5:0] opOri   = 6'h0d;
	localparam logic [5:0] opXori  = 6'h0e;
	localparam logic [5:0] opLui   = 6'h0f;

	localparam logic [5:0] fnSll = 6'h00;
	localparam logic [5:0] fnSrl = 6'h02;
	localparam logic [5:0] fnAdd = 6'h20;
	localparam logic [5:0] fnSub = 6'h22;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr  = 6'h25;
	localparam logic [5:0] fnXor = 6'h26;
	localparam logic [5:0] fnNor = 6'h27;
	localparam logic [5:0] fnSlt = 6'h2a;

endpackage

//--- logic/regFile.sv
module regFile (
	input  logic               clk,
	input  logic               rstN,
	input  execPkg::regAddr_t  rdAddrA,
	input  execPkg::regAddr_t  rdAddrB,
	output execPkg::word_t     rdDataA,
	output execPkg::word_t     rdDataB,
	input  execPkg::wbRecord_t wb
);

	execPkg::word_t regs [1:31]; // r0 is not stored

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.valid && (wb.dst != '0)) begin
			regs[wb.dst] <= wb.data;
		end
	end

	// asynchronous reads
	assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
	assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

//--- logic/operandSel.sv
module operandSel (
	input  execPkg::ctrlBundle_t ctrl,
	input  execPkg::word_t       rdDataA,
	input  execPkg::word_t       rdDataB,
	input  logic [15:0]          imm,
	input  logic [4:0]           shamt,
	input  execPkg::word_t       exData,
	input  execPkg::word_t       wbData,
	output execPkg::word_t       aluA,
	output execPkg::word_t       aluB
);

	execPkg::word_t immExt;
	execPkg::word_t fwdValA;
	execPkg::word_t fwdValB;

	function automatic execPkg::word_t applyFwd(input execPkg::fwdSel_t sel,
		input execPkg::word_t regVal, input execPkg::word_t exVal,
		input execPkg::word_t wbVal);
		case (sel)
			execPkg::fwdEx: return exVal;
			execPkg::fwdWb: return wbVal;
			default:        return regVal;
		endcase
	endfunction

	always_comb begin
		case (ctrl.ext)
			execPkg::extSign:  immExt = {{16{imm[15]}}, imm};
			execPkg::extZero:  immExt = {16'b0, imm};
			execPkg::extShamt: immExt = {27'b0, imm[10:6]};
			default:           immExt = {imm, 16'b0}; // lui
		endcase
	end

	assign fwdValA = applyFwd(ctrl.fwdA, rdDataA, exData, wbData);
	assign fwdValB = applyFwd(ctrl.fwdB, rdDataB, exData, wbData);

	assign aluA = ctrl.srcAImm ? {27'b0, shamt} : fwdValA;
	assign aluB = ctrl.srcBImm ? immExt : fwdValB;

endmodule

//--- logic/aluCore.sv
module aluCore (
	input  logic                 clk,
	input  logic                 rstN,
	input  execPkg::ctrlBundle_t ctrl,
	input  execPkg::word_t       aluA,
	input  execPkg::word_t       aluB,
	output execPkg::wbRecord_t   exRec,
	output execPkg::wbRecord_t   wbRec
);

	execPkg::word_t result;

	always_comb begin
		case (ctrl.aluOp)
			execPkg::aluAdd:   result = aluA + aluB;
			execPkg::aluSub:   result = aluA - aluB;
			execPkg::aluAnd:   result = aluA & aluB;
			execPkg::aluOr:    result = aluA | aluB;
			execPkg::aluXor:   result = aluA ^ aluB;
			execPkg::aluNor:   result = ~(aluA | aluB);
			execPkg::aluSlt:   result = {31'b0, ($signed(aluA) < $signed(aluB))};
			execPkg::aluSll:   result = aluB << aluA[4:0]; // amount from A
			execPkg::aluSrl:   result = aluB >> aluA[4:0];
			execPkg::aluPassB: result = aluB;
			default:           result = '0;
		endcase
	end

	// **********************************************************************
	// execute and writeback stages
	// **********************************************************************
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			exRec <= '0;
			wbRec <= '0;
		end else begin
			exRec.valid <= ctrl.wbEn;
			exRec.dst <= ctrl.dst;
			exRec.data <= result;
			wbRec <= exRec;
		end
	end

endmodule

//--- logic/pipeCtrl.sv
module pipeCtrl (
	input  logic                 clk,
	input  logic                 rstN,
	input  logic                 cyc,
	input  logic                 stb,
	input  logic                 we,
	input  execPkg::regAddr_t    adr,
	input  execPkg::word_t       datIn,
	input  execPkg::wbRecord_t   exRec,
	output logic                 ack,
	output execPkg::regAddr_t    rdAddrA,
	output execPkg::regAddr_t    rdAddrB,
	output execPkg::ctrlBundle_t ctrl,
	output logic [15:0]          imm,
	output logic [4:0]           shamt
);

	execPkg::busState_t busState;
	execPkg::word_t     instr;
	logic               decValid;
	execPkg::regAddr_t  wbDst;   // shadow of the writeback stage
	logic               wbValid;
	logic [5:0]         opcode;
	logic [5:0]         funct;
	execPkg::regAddr_t  rs;
	execPkg::regAddr_t  rt;
	execPkg::regAddr_t  rd;
	logic               known;
	logic               useRd;

	// earlier stage wins when both match
	function automatic execPkg::fwdSel_t pickFwd(input execPkg::regAddr_t src,
		input logic exValid, input execPkg::regAddr_t exDst,
		input logic lateValid, input execPkg::regAddr_t lateDst);
		if (exValid && (exDst == src)) begin
			return execPkg::fwdEx;
		end
		if (lateValid && (lateDst == src)) begin
			return execPkg::fwdWb;
		end
		return execPkg::fwdReg;
	endfunction

	// **********************************************************************
	// bus handshake and decode register
	// **********************************************************************
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			busState <= execPkg::busIdle;
			instr <= '0;
			decValid <= 1'b0;
			wbDst <= '0;
			wbValid <= 1'b0;
		end else begin
			if ((busState == execPkg::busIdle) && cyc && stb) begin
				busState <= execPkg::busAck;
			end else begin
				busState <= execPkg::busIdle; // one idle cycle after each ack
			end
			decValid <= ack && we;
			if (ack && we) begin
				instr <= datIn;
			end
			wbDst <= exRec.dst;
			wbValid <= exRec.valid;
		end
	end

	assign ack = (busState == execPkg::busAck);

	assign opcode = instr[31:26];
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign rd = instr[15:11];
	assign funct = instr[5:0];
	assign imm = instr[15:0];
	assign shamt = instr[10:6];

	assign rdAddrA = (ack && !we) ? adr : rs; // host read shares port A
	assign rdAddrB = rt;

	always_comb begin
		ctrl = '0;
		known = 1'b1;
		useRd = 1'b0;
		case (opcode)
			execPkg::opRType: begin
				useRd = 1'b1;
				case (funct)
					execPkg::fnAdd: ctrl.aluOp = execPkg::aluAdd;
					execPkg::fnSub: ctrl.aluOp = execPkg::aluSub;
					execPkg::fnAnd: ctrl.aluOp = execPkg::aluAnd;
					execPkg::fnOr:  ctrl.aluOp = execPkg::aluOr;
					execPkg::fnXor: ctrl.aluOp = execPkg::aluXor;
					execPkg::fnNor: ctrl.aluOp = execPkg::aluNor;
					execPkg::fnSlt: ctrl.aluOp = execPkg::aluSlt;
					execPkg::fnSll, execPkg::fnSrl: begin
						ctrl.aluOp = (funct == execPkg::fnSll) ? execPkg::aluSll : execPkg::aluSrl;
						ctrl.ext = execPkg::extShamt;
						ctrl.srcAImm = 1'b1;
					end
					default: known = 1'b0;
				endcase
			end
			execPkg::opAddi: begin
				ctrl.aluOp = execPkg::aluAdd;
				ctrl.srcBImm = 1'b1;
			end
			execPkg::opSlti: begin
				ctrl.aluOp = execPkg::aluSlt;
				ctrl.srcBImm = 1'b1;
			end
			execPkg::opAndi, execPkg::opOri, execPkg::opXori: begin
				ctrl.aluOp = (opcode == execPkg::opAndi) ? execPkg::aluAnd :
					(opcode == execPkg::opOri) ? execPkg::aluOr : execPkg::aluXor;
				ctrl.ext = execPkg::extZero;
				ctrl.srcBImm = 1'b1;
			end
			execPkg::opLui: begin
				ctrl.aluOp = execPkg::aluPassB;
				ctrl.ext = execPkg::extUpper;
				ctrl.srcBImm = 1'b1;
			end
			default: known = 1'b0;
		endcase
		ctrl.dst = useRd ? rd : rt;
		ctrl.wbEn = decValid && known && (ctrl.dst != '0); // r0 never written
		ctrl.fwdA = pickFwd(rs, exRec.valid, exRec.dst, wbValid, wbDst);
		ctrl.fwdB = pickFwd(rt, exRec.valid, exRec.dst, wbValid, wbDst);
	end

endmodule

//--- logic/execTop.sv
module execTop (
	input  logic               clk,
	input  logic               rstN,
	input  logic               cyc,
	input  logic               stb,
	input  logic               we,
	input  execPkg::regAddr_t  adr,
	input  execPkg::word_t     datIn,
	output execPkg::word_t     datOut,
	output logic               ack,
	output execPkg::wbRecord_t wbOut
);

	execPkg::regAddr_t    rdAddrA;
	execPkg::regAddr_t    rdAddrB;
	execPkg::word_t       rdDataA;
	execPkg::word_t       rdDataB;
	execPkg::ctrlBundle_t ctrl;
	logic [15:0]          imm;
	logic [4:0]           shamt;
	execPkg::word_t       aluA;
	execPkg::word_t       aluB;
	execPkg::wbRecord_t   exRec;
	execPkg::wbRecord_t   wbRec;

	pipeCtrl u_ctrl (
		.clk     (clk),
		.rstN    (rstN),
		.cyc     (cyc),
		.stb     (stb),
		.we      (we),
		.adr     (adr),
		.datIn   (datIn),
		.exRec   (exRec),
		.ack     (ack),
		.rdAddrA (rdAddrA),
		.rdAddrB (rdAddrB),
		.ctrl    (ctrl),
		.imm     (imm),
		.shamt   (shamt)
	);

	regFile u_regs (
		.clk     (clk),
		.rstN    (rstN),
		.rdAddrA (rdAddrA),
		.rdAddrB (rdAddrB),
		.rdDataA (rdDataA),
		.rdDataB (rdDataB),
		.wb      (wbRec) // committed one cycle after wbOut
	);

	operandSel u_opSel (
		.ctrl    (ctrl),
		.rdDataA (rdDataA),
		.rdDataB (rdDataB),
		.imm     (imm),
		.shamt   (shamt),
		.exData  (exRec.data),
		.wbData  (wbRec.data),
		.aluA    (aluA),
		.aluB    (aluB)
	);

	aluCore u_alu (
		.clk   (clk),
		.rstN  (rstN),
		.ctrl  (ctrl),
		.aluA  (aluA),
		.aluB  (aluB),
		.exRec (exRec),
		.wbRec (wbRec)
	);

	assign datOut = rdDataA; // valid while ack is high on a read
	assign wbOut = wbRec;

endmodule

//--- sim/execTop_chk.sv
module execTopChk (
	input logic               clk,
	input logic               rstN,
	input logic               cyc,
	input logic               stb,
	input logic               ack,
	input execPkg::wbRecord_t wbOut
);

	ackOnePulse: assert property (@(posedge clk) disable iff (!rstN) ack |=> !ack)
		else $error("ack high on two consecutive cycles");

	// ack is registered from a sampled request
	ackNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
		ack |-> $past(cyc && stb))
		else $error("ack without a preceding cyc and stb");

	wbNotR0: assert property (@(posedge clk) disable iff (!rstN)
		wbOut.valid |-> (wbOut.dst != '0))
		else $error("writeback record reports destination r0");

endmodule

bind execTop execTopChk u_chk (
	.clk   (clk),
	.rstN  (rstN),
	.cyc   (cyc),
	.stb   (stb),
	.ack   (ack),
	.wbOut (wbOut)
);

//--- sim/execTb.sv
module execTb;

	logic                clk;
	logic                rstN;
	logic                cyc;
	logic                stb;
	logic                we;
	execPkg::regAddr_t   adr;
	execPkg::word_t      datIn;
	execPkg::word_t      datOut;
	logic                ack;
	execPkg::wbRecord_t  wbOut;

	execPkg::wbRecord_t  expQ[$];
	execPkg::wbRecord_t  gotQ[$];
	int                  passCnt;
	int                  failCnt;
	int                  grpPass0;
	int                  grpFail0;
	int                  lineCnt;
	logic [31:0]         rngState;
	string               groupName;

	execTop u_dut (
		.clk    (clk),
		.rstN   (rstN),
		.cyc    (cyc),
		.stb    (stb),
		.we     (we),
		.adr    (adr),
		.datIn  (datIn),
		.datOut (datOut),
		.ack    (ack),
		.wbOut  (wbOut)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// **********************************************************************
	// bus cycle and compare tasks
	// **********************************************************************
	task automatic busCycle(input logic wr, input execPkg::regAddr_t a,
		input execPkg::word_t d, input int gap, output execPkg::word_t q);
		int waited;
		waited = 0;
		if (gap > 0) begin
			cyc = 1'b0;
			stb = 1'b0;
			repeat (gap) @(posedge clk);
			#1;
		end
		cyc = 1'b1; // held high across zero-gap transfers
		stb = 1'b1;
		we = wr;
		adr = a;
		datIn = d;
		@(negedge clk);
		while (!ack && (waited < 20)) begin
			@(negedge clk);
			waited++;
		end
		if (!ack) begin
			$display("no ack from the DUT at time %0t", $time);
			failCnt++;
		end
		q = datOut;
		@(posedge clk); // transfer completes here
		#1;
	endtask

	task automatic checkRec(input execPkg::wbRecord_t got, input execPkg::wbRecord_t exp);
		if (got !== exp) begin
			$display("MISMATCH t=%0t writeback got v=%0b r%0d=%h, expected v=%0b r%0d=%h",
				$time, got.valid, got.dst, got.data, exp.valid, exp.dst, exp.data);
			failCnt++;
		end else begin
			passCnt++;
		end
	endtask

	task automatic checkWord(input execPkg::word_t got, input execPkg::word_t exp,
		input execPkg::regAddr_t r);
		if (got !== exp) begin
			$display("MISMATCH t=%0t read r%0d got %h expected %h", $time, r, got, exp);
			failCnt++;
		end else begin
			passCnt++;
		end
	endtask

	task automatic closeGroup();
		execPkg::wbRecord_t exp;
		execPkg::wbRecord_t got;
		cyc = 1'b0;
		stb = 1'b0;
		repeat (8) @(posedge clk); // drain the pipeline into the register file
		#1;
		while (expQ.size() > 0) begin
			exp = expQ.pop_front();
			if (gotQ.size() == 0) begin
				$display("writeback for r%0d never appeared in group %s", exp.dst, groupName);
				failCnt++;
			end else begin
				got = gotQ.pop_front();
				checkRec(got, exp);
			end
		end
		while (gotQ.size() > 0) begin
			got = gotQ.pop_front();
			$display("unexpected writeback to r%0d in group %s", got.dst, groupName);
			failCnt++;
		end
		$display("group %s: %0d passed, %0d failed", groupName, passCnt - grpPass0,
			failCnt - grpFail0);
		grpPass0 = passCnt;
		grpFail0 = failCnt;
	endtask

	// every completed result lands in the queue
	initial begin
		forever begin
			@(negedge clk);
			if (rstN && wbOut.valid) begin
				gotQ.push_back(wbOut);
			end
		end
	end

	initial begin
		wait (lineCnt > 0);
		repeat (lineCnt * 40 + 200) @(posedge clk);
		$display("watchdog expired, trace did not finish in time");
		$display("SIMULATION FAILED");
		$finish;
	end

	// **********************************************************************
	// trace player
	// **********************************************************************
	initial begin
		int                 fd;
		int                 gap;
		int                 lines;
		string              line;
		string              tag;
		string              dstTok;
		execPkg::word_t     instr;
		execPkg::word_t     expWord;
		execPkg::word_t     rdata;
		execPkg::regAddr_t  regNum;
		execPkg::wbRecord_t expRec;
		rstN = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		datIn = '0;
		passCnt = 0;
		failCnt = 0;
		grpPass0 = 0;
		grpFail0 = 0;
		lineCnt = 0;
		rngState = 32'd51596;
		groupName = "";
		repeat (5) @(posedge clk);
		#1;
		rstN = 1'b1;
		fd = $fopen("sim/exec_trace.txt", "r");
		if (fd == 0) begin
			$display("cannot open sim/exec_trace.txt");
			failCnt++;
		end else begin
			lines = 0;
			while (!$feof(fd)) begin
				if ($fgets(line, fd) != 0) begin
					lines++;
				end
			end
			$fclose(fd);
			lineCnt = lines; // watchdog starts once the whole trace is counted
			fd = $fopen("sim/exec_trace.txt", "r");
			while ($fscanf(fd, "%s", tag) == 1) begin
				rngState = xorshift32(rngState);
				gap = (groupName == "fwd") ? 0 : int'(rngState % 4); // fwd runs back to back
				if (tag == "#") begin
					void'($fgets(line, fd)); // rest of a comment
				end else if (tag == "G") begin
					if (groupName != "") begin
						closeGroup();
					end
					void'($fscanf(fd, "%s", groupName));
				end else if (tag == "W") begin
					void'($fscanf(fd, "%h %s", instr, dstTok));
					if (dstTok != "none") begin
						void'($sscanf(dstTok, "%h", regNum));
						void'($fscanf(fd, "%h", expWord));
						expRec.valid = 1'b1;
						expRec.dst = regNum;
						expRec.data = expWord;
						expQ.push_back(expRec);
					end
					busCycle(1'b1, '0, instr, gap, rdata);
				end else if (tag == "R") begin
					void'($fscanf(fd, "%h %h", regNum, expWord));
					busCycle(1'b0, regNum, '0, gap, rdata);
					checkWord(rdata, expWord, regNum);
				end else begin
					$display("trace holds an unknown line type %s", tag);
					failCnt++;
				end
			end
			$fclose(fd);
			if (groupName != "") begin
				closeGroup();
			end
		end
		$display("checks passed %0d, failed %0d", passCnt, failCnt);
		if (failCnt == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

//--- sim/exec_trace.txt
# columns, all hex: W instr dst data | W instr none | R reg value | G group
# W writes an instruction, R reads a register, G starts a test group
G itype
W 20010005 01 00000005 # addi r1, r0, 5
W 2002fffd 02 fffffffd # addi r2, r0, -3
W 28430001 03 00000001 # slti r3, r2, 1
W 34048001 04 00008001 # ori r4, r0, 0x8001
W 3045f0f0 05 0000f0f0 # andi r5, r2, 0xf0f0
W 3826ffff 06 0000fffa # xori r6, r1, 0xffff
W 3c071234 07 12340000 # lui r7, 0x1234
W 00044100 08 00080010 # sll r8, r4, 4
W 00024f02 09 0000000f # srl r9, r2, 28
G rtype
W 00225020 0a 00000002 # add r10, r1, r2
W 00415822 0b fffffff8 # sub r11, r2, r1
W 00446024 0c 00008001 # and r12, r2, r4
W 00276825 0d 12340005 # or r13, r1, r7
W 00467026 0e ffff0007 # xor r14, r2, r6
W 00247827 0f ffff7ffa # nor r15, r1, r4
W 004b802a 10 00000000 # slt r16, r2, r11
W 0162882a 11 00000001 # slt r17, r11, r2
G fwd
W 20320010 12 00000015 # addi r18, r1, 16
W 02529820 13 0000002a # add r19, r18, r18
W 0272a022 14 00000015 # sub r20, r19, r18
W 22520001 12 00000016 # addi r18, r18, 1
W 22520002 12 00000018 # addi r18, r18, 2
W 0254a820 15 0000002d # add r21, r18, r20
W 02b3b022 16 00000003 # sub r22, r21, r19
G nowrite
W 20200007 none # addi r0, r1, 7
W 00220020 none # add r0, r1, r2
W fc171234 none # unknown opcode 0x3f
W 0022c03f none # unknown funct 0x3f to r24
W 20170042 17 00000042 # addi r23, r0, 0x42
R 00 00000000
G readback
R 01 00000005
R 02 fffffffd
R 03 00000001
R 05 0000f0f0
R 07 12340000
R 09 0000000f
R 0b fffffff8
R 0f ffff7ffa
R 11 00000001
R 12 00000018
R 15 0000002d
R 16 00000003
R 17 00000042
R 18 00000000
R 00 00000000

//--- tb.f
logic/execPkg.sv
logic/regFile.sv
logic/operandSel.sv
logic/aluCore.sv
logic/pipeCtrl.sv
logic/execTop.sv
sim/execTop_chk.sv
sim/execTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= execTb
OBJ_DIR   ?= obj_dir
FILELIST  ?= tb.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= SIMULATION FAILED
PASS_MSG  ?= SIMULATION PASSED

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
